//--- verilog/core_pkg.sv
// Core package with RV32I widths, opcode and funct3 encodings, ALU operations
package core_pkg;

	localparam int XLEN    = 32;
	localparam int REG_NUM = 32;

	typedef logic [XLEN-1:0]            word_t;
	typedef logic [$clog2(REG_NUM)-1:0] reg_idx_t;
	typedef logic [6:0]                 opcode_t;

	localparam word_t RESET_PC = '0;

	// Opcodes kept by this core
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;

	// funct3 of the ALU groups
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;	// SRL/SRA by funct7 bit
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// Word access width for LW/SW
	localparam logic [2:0] F3_WORD = 3'b010;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS	// LUI, second operand straight through
	} alu_op_e;

endpackage

//--- verilog/core_ifu.sv
// Fetch unit with program counter, instruction bus request and instruction buffer
`timescale 1ns/100ps

module core_ifu import core_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,

	output logic  imem_req_valid,
	output word_t imem_addr,
	input  logic  imem_rsp_valid,
	input  word_t imem_rsp_inst,

	output logic  id_valid,
	input  logic  id_ready,
	output word_t id_inst,
	output word_t id_pc
);

	typedef enum logic [1:0] {
		S_REQ,	// launch cycle out of reset
		S_WAIT,	// request on the bus
		S_HOLD	// buffer full, waiting for decode
	} state_e;

	state_e state;
	word_t  pc;
	word_t  inst_buf;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_REQ;
			pc    <= RESET_PC;
		end else begin
			case (state)
				S_REQ:  state <= S_WAIT;
				S_WAIT: if (imem_rsp_valid) state <= S_HOLD;
				S_HOLD: begin
					if (id_ready) begin
						state <= S_WAIT;	// next request right away
						pc    <= pc + word_t'(4);
					end
				end
				default: state <= S_REQ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_WAIT && imem_rsp_valid)
			inst_buf <= imem_rsp_inst;
	end

	assign imem_req_valid = (state == S_WAIT);
	assign imem_addr      = pc;	// held with the request

	assign id_valid = (state == S_HOLD);
	assign id_inst  = inst_buf;
	assign id_pc    = pc;

endmodule

//--- verilog/core_idu.sv
// Decode and issue unit with operand read and hazard stall towards EXU and LSU
`timescale 1ns/100ps

module core_idu import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     id_valid,
	output logic     id_ready,
	input  word_t    id_inst,
	input  word_t    id_pc,

	output reg_idx_t rs1_idx,
	output reg_idx_t rs2_idx,
	input  word_t    rs1_data,
	input  word_t    rs2_data,
	input  logic     ops_ready,
	output logic     issue_set,
	output reg_idx_t issue_rd,

	output logic     ex_valid,
	input  logic     ex_ready,
	output alu_op_e  ex_op,
	output word_t    ex_a,
	output word_t    ex_b,
	output reg_idx_t ex_rd,

	output logic     ls_valid,
	input  logic     ls_ready,
	output logic     ls_wen,
	output word_t    ls_base,
	output word_t    ls_offset,
	output word_t    ls_wdata,
	output reg_idx_t ls_rd
);

	logic       inst_vld;
	word_t      inst_q;
	opcode_t    opcode;
	logic [2:0] f3;
	logic       f7_alt;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_u;
	word_t      imm;
	logic       is_alu;
	logic       is_mem;
	logic       use_rs1;
	logic       use_rs2;
	alu_op_e    op;
	logic       ld_last;
	logic       ld_busy;
	logic       ex_fire;
	logic       ls_fire;
	logic       done;

	function automatic alu_op_e alu_from_f3(input logic [2:0] fn, input logic alt,
		input logic reg_form);
		case (fn)
			F3_ADD:  alu_from_f3 = (alt && reg_form) ? ALU_SUB : ALU_ADD;
			F3_SLL:  alu_from_f3 = ALU_SLL;
			F3_SLT:  alu_from_f3 = ALU_SLT;
			F3_SLTU: alu_from_f3 = ALU_SLTU;
			F3_XOR:  alu_from_f3 = ALU_XOR;
			F3_SR:   alu_from_f3 = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   alu_from_f3 = ALU_OR;
			default: alu_from_f3 = ALU_AND;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inst_vld <= 1'b0;
			ld_last  <= 1'b0;
		end else begin
			if (id_valid && id_ready)
				inst_vld <= 1'b1;
			else if (done)
				inst_vld <= 1'b0;
			if (ls_fire)
				ld_last <= ~ls_wen;
		end
	end

	always_ff @(posedge clk) begin
		if (id_valid && id_ready)
			inst_q <= id_inst;
	end

	assign opcode = inst_q[6:0];
	assign f3     = inst_q[14:12];
	assign f7_alt = inst_q[30];
	assign imm_i  = {{20{inst_q[31]}}, inst_q[31:20]};
	assign imm_s  = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
	assign imm_u  = {inst_q[31:12], 12'b0};

	always_comb begin
		is_alu  = 1'b0;
		is_mem  = 1'b0;
		use_rs1 = 1'b1;
		use_rs2 = 1'b0;
		op      = ALU_ADD;
		imm     = imm_i;
		case (opcode)
			OPC_LUI: begin
				is_alu  = 1'b1;
				use_rs1 = 1'b0;
				op      = ALU_PASS;
				imm     = imm_u;
			end
			OPC_OP_IMM: begin
				is_alu = 1'b1;
				op     = alu_from_f3(f3, f7_alt, 1'b0);
			end
			OPC_OP: begin
				is_alu  = 1'b1;
				use_rs2 = 1'b1;
				op      = alu_from_f3(f3, f7_alt, 1'b1);
			end
			OPC_LOAD: is_mem = (f3 == F3_WORD);
			OPC_STORE: begin
				is_mem  = (f3 == F3_WORD);
				use_rs2 = 1'b1;
				imm     = imm_s;
			end
			default: use_rs1 = 1'b0;	// Anything else retires as a NOP
		endcase
	end

	// Unused sources read x0, which is never busy
	assign rs1_idx = use_rs1 ? inst_q[19:15] : '0;
	assign rs2_idx = use_rs2 ? inst_q[24:20] : '0;

	// ALU results must not overtake an outstanding load
	assign ld_busy = ld_last & ~ls_ready;

	assign ex_valid = inst_vld & is_alu & ops_ready & ~ld_busy;
	assign ls_valid = inst_vld & is_mem & ops_ready;
	assign ex_fire  = ex_valid & ex_ready;
	assign ls_fire  = ls_valid & ls_ready;
	assign done     = ex_fire | ls_fire | (inst_vld & ~is_alu & ~is_mem);
	assign id_ready = ~inst_vld | done;

	assign issue_set = ex_fire | (ls_fire & (opcode == OPC_LOAD));
	assign issue_rd  = inst_q[11:7];

	assign ex_op = op;
	assign ex_a  = rs1_data;
	assign ex_b  = use_rs2 ? rs2_data : imm;
	assign ex_rd = inst_q[11:7];

	assign ls_wen    = (opcode == OPC_STORE);
	assign ls_base   = rs1_data;
	assign ls_offset = imm;
	assign ls_wdata  = rs2_data;
	assign ls_rd     = inst_q[11:7];

endmodule

//--- verilog/core_exu.sv
// Execution unit with the ALU and a result register towards write-back
`timescale 1ns/100ps

module core_exu import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     ex_valid,
	output logic     ex_ready,
	input  alu_op_e  ex_op,
	input  word_t    ex_a,
	input  word_t    ex_b,
	input  reg_idx_t ex_rd,

	output logic     wb_valid,
	input  logic     wb_ready,
	output reg_idx_t wb_rd,
	output word_t    wb_data
);

	word_t      res;
	logic [4:0] shamt;

	assign shamt = ex_b[4:0];

	always_comb begin
		case (ex_op)
			ALU_ADD:  res = ex_a + ex_b;
			ALU_SUB:  res = ex_a - ex_b;
			ALU_SLL:  res = ex_a << shamt;
			ALU_SLT:  res = word_t'($signed(ex_a) < $signed(ex_b));
			ALU_SLTU: res = word_t'(ex_a < ex_b);
			ALU_XOR:  res = ex_a ^ ex_b;
			ALU_SRL:  res = ex_a >> shamt;
			ALU_SRA:  res = word_t'($signed(ex_a) >>> shamt);
			ALU_OR:   res = ex_a | ex_b;
			ALU_AND:  res = ex_a & ex_b;
			default:  res = ex_b;	// ALU_PASS
		endcase
	end

	// Empty or draining this cycle
	assign ex_ready = ~wb_valid | wb_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else if (ex_valid && ex_ready)
			wb_valid <= 1'b1;
		else if (wb_ready)
			wb_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (ex_valid && ex_ready) begin
			wb_rd   <= ex_rd;
			wb_data <= res;
		end
	end

endmodule

//--- verilog/core_lsu.sv
// Load/store unit for word accesses over the data bus
`timescale 1ns/100ps

module core_lsu import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     ls_valid,
	output logic     ls_ready,
	input  logic     ls_wen,
	input  word_t    ls_base,
	input  word_t    ls_offset,
	input  word_t    ls_wdata,
	input  reg_idx_t ls_rd,

	output logic     dmem_req_valid,
	output logic     dmem_wen,
	output word_t    dmem_addr,
	output word_t    dmem_wdata,
	input  logic     dmem_req_ready,
	input  logic     dmem_rsp_valid,
	input  word_t    dmem_rsp_rdata,
	output logic     dmem_rsp_ready,

	output logic     wb_valid,
	input  logic     wb_ready,
	output reg_idx_t wb_rd,
	output word_t    wb_data
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_RSP,
		S_WB
	} state_e;

	state_e   state;
	logic     wen_q;
	word_t    addr_q;
	word_t    wdata_q;
	reg_idx_t rd_q;
	word_t    rdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (ls_valid) state <= S_REQ;
				S_REQ:  if (dmem_req_ready) state <= wen_q ? S_IDLE : S_RSP;	// Store done here
				S_RSP:  if (dmem_rsp_valid) state <= S_WB;
				S_WB:   if (wb_ready) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ls_valid && ls_ready) begin
			wen_q   <= ls_wen;
			addr_q  <= ls_base + ls_offset;
			wdata_q <= ls_wdata;
			rd_q    <= ls_rd;
		end
		if (state == S_RSP && dmem_rsp_valid)
			rdata_q <= dmem_rsp_rdata;
	end

	assign ls_ready = (state == S_IDLE);

	assign dmem_req_valid = (state == S_REQ);
	assign dmem_wen       = wen_q;
	assign dmem_addr      = addr_q;
	assign dmem_wdata     = wdata_q;
	assign dmem_rsp_ready = (state == S_RSP);

	assign wb_valid = (state == S_WB);
	assign wb_rd    = rd_q;
	assign wb_data  = rdata_q;

endmodule

//--- verilog/core_gpr.sv
// General purpose registers with two read ports and a load-first write arbiter
`timescale 1ns/100ps

module core_gpr import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  reg_idx_t rs1_idx,
	input  reg_idx_t rs2_idx,
	output word_t    rs1_data,
	output word_t    rs2_data,

	input  logic     ex_wb_valid,
	output logic     ex_wb_ready,
	input  reg_idx_t ex_wb_rd,
	input  word_t    ex_wb_data,

	input  logic     ls_wb_valid,
	output logic     ls_wb_ready,
	input  reg_idx_t ls_wb_rd,
	input  word_t    ls_wb_data,

	output logic     clr_valid,
	output reg_idx_t clr_idx
);

	word_t regs [1:REG_NUM-1];
	word_t wr_data;

	// LSU always wins the write port
	assign ls_wb_ready = 1'b1;
	assign ex_wb_ready = ~ls_wb_valid;

	assign clr_valid = ls_wb_valid | ex_wb_valid;
	assign clr_idx   = ls_wb_valid ? ls_wb_rd : ex_wb_rd;
	assign wr_data   = ls_wb_valid ? ls_wb_data : ex_wb_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < REG_NUM; i++)
				regs[i] <= '0;
		end else if (clr_valid && clr_idx != '0) begin
			regs[clr_idx] <= wr_data;
		end
	end

	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- verilog/core_scb.sv
// Scoreboard of registers waiting for write-back
`timescale 1ns/100ps

module core_scb import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  reg_idx_t rs1_idx,
	input  reg_idx_t rs2_idx,
	output logic     ops_ready,

	input  logic     issue_set,
	input  reg_idx_t issue_rd,

	input  logic     clr_valid,
	input  reg_idx_t clr_idx
);

	logic [REG_NUM-1:0] busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= '0;
		end else begin
			if (clr_valid)
				busy[clr_idx] <= 1'b0;
			// Set after clear so a new owner of the same rd stays busy
			if (issue_set && issue_rd != '0)
				busy[issue_rd] <= 1'b1;
		end
	end

	assign ops_ready = ~busy[rs1_idx] & ~busy[rs2_idx];

endmodule

//--- verilog/core_top.sv
// Core top level connecting fetch, decode, execute, load/store, registers and scoreboard
`timescale 1ns/100ps

module core_top import core_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,

	output logic  imem_req_valid,
	output word_t imem_addr,
	input  logic  imem_rsp_valid,
	input  word_t imem_rsp_inst,

	output logic  dmem_req_valid,
	output logic  dmem_wen,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	input  logic  dmem_req_ready,
	input  logic  dmem_rsp_valid,
	input  word_t dmem_rsp_rdata,
	output logic  dmem_rsp_ready
);

	// Fetch to decode
	logic     id_valid;
	logic     id_ready;
	word_t    id_inst;
	word_t    id_pc;

	// Operand read and hazard check
	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	word_t    rs1_data;
	word_t    rs2_data;
	logic     ops_ready;
	logic     issue_set;
	reg_idx_t issue_rd;
	logic     clr_valid;
	reg_idx_t clr_idx;

	// Issue to EXU
	logic     ex_valid;
	logic     ex_ready;
	alu_op_e  ex_op;
	word_t    ex_a;
	word_t    ex_b;
	reg_idx_t ex_rd;

	// Issue to LSU
	logic     ls_valid;
	logic     ls_ready;
	logic     ls_wen;
	word_t    ls_base;
	word_t    ls_offset;
	word_t    ls_wdata;
	reg_idx_t ls_rd;

	// Write-back
	logic     ex_wb_valid;
	logic     ex_wb_ready;
	reg_idx_t ex_wb_rd;
	word_t    ex_wb_data;
	logic     ls_wb_valid;
	logic     ls_wb_ready;
	reg_idx_t ls_wb_rd;
	word_t    ls_wb_data;

	core_ifu u_core_ifu (
		.clk, .rst_n,
		.imem_req_valid, .imem_addr, .imem_rsp_valid, .imem_rsp_inst,
		.id_valid, .id_ready, .id_inst, .id_pc
	);

	core_idu u_core_idu (
		.clk, .rst_n,
		.id_valid, .id_ready, .id_inst, .id_pc,
		.rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
		.ops_ready, .issue_set, .issue_rd,
		.ex_valid, .ex_ready, .ex_op, .ex_a, .ex_b, .ex_rd,
		.ls_valid, .ls_ready, .ls_wen, .ls_base, .ls_offset, .ls_wdata, .ls_rd
	);

	core_exu u_core_exu (
		.clk, .rst_n,
		.ex_valid, .ex_ready, .ex_op, .ex_a, .ex_b, .ex_rd,
		.wb_valid (ex_wb_valid),
		.wb_ready (ex_wb_ready),
		.wb_rd    (ex_wb_rd),
		.wb_data  (ex_wb_data)
	);

	core_lsu u_core_lsu (
		.clk, .rst_n,
		.ls_valid, .ls_ready, .ls_wen, .ls_base, .ls_offset, .ls_wdata, .ls_rd,
		.dmem_req_valid, .dmem_wen, .dmem_addr, .dmem_wdata, .dmem_req_ready,
		.dmem_rsp_valid, .dmem_rsp_rdata, .dmem_rsp_ready,
		.wb_valid (ls_wb_valid),
		.wb_ready (ls_wb_ready),
		.wb_rd    (ls_wb_rd),
		.wb_data  (ls_wb_data)
	);

	core_gpr u_core_gpr (
		.clk, .rst_n,
		.rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
		.ex_wb_valid, .ex_wb_ready, .ex_wb_rd, .ex_wb_data,
		.ls_wb_valid, .ls_wb_ready, .ls_wb_rd, .ls_wb_data,
		.clr_valid, .clr_idx
	);

	core_scb u_core_scb (
		.clk, .rst_n,
		.rs1_idx, .rs2_idx, .ops_ready,
		.issue_set, .issue_rd,
		.clr_valid, .clr_idx
	);

endmodule

//--- testbench/tb_core_ref.svh
// Instruction encoders, program builders and the architectural reference model
`ifndef TB_CORE_REF_SVH
`define TB_CORE_REF_SVH

word_t ref_regs [32];
word_t ref_mem  [256];

function automatic word_t enc_i(input opcode_t opc, input logic [2:0] f3, input int rd,
	input int rs1, input int imm);
	return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
endfunction

function automatic word_t enc_r(input logic alt, input logic [2:0] f3, input int rd,
	input int rs1, input int rs2);
	return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
endfunction

function automatic word_t enc_sw(input int rs2, input int rs1, input int imm);
	return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OPC_STORE};
endfunction

function automatic word_t enc_lui(input int rd, input int imm20);
	return {imm20[19:0], rd[4:0], OPC_LUI};
endfunction

// Initial data memory content, a function of the whole byte address
function automatic word_t fill_word(input int idx);
	word_t addr;
	addr = word_t'(idx) << 2;
	return {addr[15:0] ^ 16'h5a3c, ~addr[15:0]};
endfunction

function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
	input word_t b);
	case (f3)
		F3_ADD:  return alt ? a - b : a + b;
		F3_SLL:  return a << b[4:0];
		F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
		F3_XOR:  return a ^ b;
		F3_SR:   return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
		F3_OR:   return a | b;
		default: return a & b;
	endcase
endfunction

// Runs prog sequentially and records every store in order
function automatic void ref_run();
	word_t inst;
	word_t a;
	word_t b;
	word_t addr;
	word_t res;
	logic  wr;
	foreach (ref_regs[i]) ref_regs[i] = '0;
	foreach (ref_mem[i]) ref_mem[i] = fill_word(i);
	exp_addr_q.delete();
	exp_data_q.delete();
	foreach (prog[p]) begin
		inst = prog[p];
		a    = ref_regs[inst[19:15]];
		b    = ref_regs[inst[24:20]];
		wr   = 1'b1;
		res  = '0;
		case (inst[6:0])
			OPC_LUI:    res = {inst[31:12], 12'h000};
			OPC_OP_IMM: res = alu_ref(inst[14:12], inst[30] && inst[14:12] == F3_SR, a,
				{{20{inst[31]}}, inst[31:20]});
			OPC_OP:     res = alu_ref(inst[14:12], inst[30], a, b);
			OPC_LOAD: begin
				addr = a + {{20{inst[31]}}, inst[31:20]};
				res  = ref_mem[addr[9:2]];
			end
			OPC_STORE: begin
				addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
				ref_mem[addr[9:2]] = b;
				exp_addr_q.push_back(addr);
				exp_data_q.push_back(b);
				wr = 1'b0;
			end
			default: wr = 1'b0;
		endcase
		if (wr && inst[11:7] != 5'd0)
			ref_regs[inst[11:7]] = res;
	end
endfunction

`endif

//--- testbench/tb_core.sv
// Testbench for the RV32I core with bus models and a store stream checker
`timescale 1ns/100ps

module tb_core import core_pkg::*; ();

	logic  clk;
	logic  rst_n;
	logic  imem_req_valid;
	word_t imem_addr;
	logic  imem_rsp_valid;
	word_t imem_rsp_inst;
	logic  dmem_req_valid;
	logic  dmem_wen;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic  dmem_req_ready;
	logic  dmem_rsp_valid;
	word_t dmem_rsp_rdata;
	logic  dmem_rsp_ready;

	word_t prog [$];
	word_t exp_addr_q [$];
	word_t exp_data_q [$];
	word_t dmem [256];
	int    seed = 68126;
	int    errors;
	int    checks;
	int    tests;
	int    seen;
	int    ilat;
	int    dlat;
	word_t ld_data;
	logic  st_fire;
	word_t st_addr;
	word_t st_data;
	logic  hung;

	`include "tb_core_ref.svh"

	core_top u_core_top (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int rnd(input int n);
		return {$random(seed)} % n;
	endfunction

	task automatic check(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Bus models, all driven on the falling edge
	always @(negedge clk) begin
		imem_rsp_valid = 1'b0;
		dmem_rsp_valid = 1'b0;
		st_fire        = 1'b0;
		dmem_req_ready = 1'b0;
		if (!rst_n) begin
			ilat = 0;
			dlat = 0;
		end else begin
			if (imem_req_valid) begin
				if (ilat == 0)
					ilat = 1 + rnd(3);
				ilat--;
				if (ilat == 0) begin
					imem_rsp_valid = 1'b1;
					imem_rsp_inst  = (imem_addr[31:2] < prog.size()) ? prog[imem_addr[31:2]] :
						enc_i(OPC_OP_IMM, F3_ADD, 0, 0, 0);
				end
			end
			dmem_req_ready = (rnd(3) != 0);
			// Handshake lands on the next rising edge
			if (dmem_req_valid && dmem_req_ready) begin
				if (dmem_wen) begin
					st_fire = 1'b1;
					st_addr = dmem_addr;
					st_data = dmem_wdata;
					dmem[dmem_addr[9:2]] = dmem_wdata;
				end else begin
					ld_data = dmem[dmem_addr[9:2]];
					dlat    = 1 + rnd(4);
				end
			end else if (dmem_rsp_ready && dlat > 0) begin
				dlat--;
				if (dlat == 0) begin
					dmem_rsp_valid = 1'b1;
					dmem_rsp_rdata = ld_data;
				end
			end
		end
	end

	// Store stream compare
	always @(posedge clk) begin
		if (st_fire) begin
			if (exp_addr_q.size() == 0) begin
				errors++;
				$display("Unexpected extra store of %h to address %h", st_data, st_addr);
			end else begin
				check("dmem_addr", st_addr, exp_addr_q.pop_front());
				check("dmem_wdata", st_data, exp_data_q.pop_front());
				seen++;
			end
		end
	end

	task automatic run_test(input string name);
		int limit;
		int cyc;
		int total;
		int err0;
		logic first;
		if (hung)
			return;
		ref_run();
		total = exp_addr_q.size();
		limit = 200 * prog.size();
		err0  = errors;
		seen  = 0;
		cyc   = 0;
		first = 1'b1;
		foreach (dmem[i]) dmem[i] = fill_word(i);
		rst_n = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check("imem_req_valid", imem_req_valid, 0);
			check("dmem_req_valid", dmem_req_valid, 0);
			check("dmem_rsp_ready", dmem_rsp_ready, 0);
		end
		rst_n = 1'b1;
		while (seen < total && cyc < limit) begin
			@(negedge clk);
			cyc++;
			if (first && imem_req_valid) begin
				check("imem_addr", imem_addr, 32'h0);
				first = 1'b0;
			end
		end
		if (seen < total) begin
			$display("Timeout in test %s: %0d of %0d stores seen after %0d cycles",
				name, seen, total, cyc);
			errors++;
			hung = 1'b1;
		end else begin
			repeat (40) @(negedge clk);	// catch stray stores
			tests++;
			$display("Test %s done: %0d stores, %0d errors", name, total, errors - err0);
		end
	endtask

	task automatic build_imm();
		prog.delete();
		prog.push_back(enc_lui(1, 20'h80f3c));
		prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, 1, 1, -1321));
		prog.push_back(enc_sw(1, 0, 0));
		for (int f = 0; f < 8; f++) begin
			prog.push_back(enc_i(OPC_OP_IMM, f[2:0], 2, 1,
				(f == 1) ? 7 : (f == 5) ? 32'h409 : -300 + 97 * f));
			prog.push_back(enc_sw(2, 0, 4 + 4 * f));
		end
		prog.push_back(enc_i(OPC_OP_IMM, F3_SR, 3, 1, 12));
		prog.push_back(enc_sw(3, 0, 40));
	endtask

	task automatic build_reg();
		prog.delete();
		prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, 1, 0, -20));
		prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, 2, 0, 7));
		prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, 3, 0, -3));
		prog.push_back(enc_r(1'b1, F3_ADD, 4, 2, 1));
		prog.push_back(enc_r(1'b1, F3_SR, 5, 1, 2));
		prog.push_back(enc_r(1'b0, F3_SLT, 6, 1, 2));
		prog.push_back(enc_r(1'b0, F3_SLTU, 7, 2, 1));
		prog.push_back(enc_r(1'b0, F3_SLTU, 8, 1, 3));
		for (int r = 4; r <= 8; r++)
			prog.push_back(enc_sw(r, 0, 64 + 4 * r));
	endtask

	task automatic build_hazard();
		prog.delete();
		prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, 1, 0, 5));
		prog.push_back(enc_r(1'b0, F3_ADD, 2, 1, 1));
		prog.push_back(enc_r(1'b1, F3_ADD, 3, 2, 1));
		prog.push_back(enc_r(1'b0, F3_XOR, 4, 3, 2));
		prog.push_back(enc_i(OPC_OP_IMM, F3_SLL, 4, 4, 3));
		prog.push_back(enc_sw(4, 0, 128));
		prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, 0, 1, 7));
		prog.push_back(enc_r(1'b0, F3_ADD, 5, 0, 1));
		prog.push_back(enc_sw(5, 0, 132));
	endtask

	task automatic build_mem();
		prog.delete();
		prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, 1, 0, 291));
		prog.push_back(enc_sw(1, 0, 16));
		prog.push_back(enc_i(OPC_LOAD, F3_WORD, 2, 0, 16));
		prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, 3, 2, 1));
		prog.push_back(enc_sw(3, 0, 20));
		prog.push_back(enc_i(OPC_LOAD, F3_WORD, 4, 0, 36));
		prog.push_back(enc_r(1'b0, F3_ADD, 5, 4, 3));
		prog.push_back(enc_sw(5, 0, 24));
	endtask

	task automatic build_random();
		int f;
		prog.delete();
		for (int r = 1; r < 8; r++)
			prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, r, 0, rnd(4096) - 2048));
		for (int k = 0; k < 40; k++) begin
			f = rnd(8);
			case (rnd(10))
				0: prog.push_back(enc_lui(rnd(8), rnd(1 << 20)));
				1, 2, 3: prog.push_back(enc_i(OPC_OP_IMM, f[2:0], rnd(8), rnd(8),
					(f == 1) ? rnd(32) : (f == 5) ? rnd(32) + 1024 * rnd(2) : rnd(4096)));
				4, 5, 6: prog.push_back(enc_r((f == 0 || f == 5) && rnd(2) == 1, f[2:0],
					rnd(8), rnd(8), rnd(8)));
				7, 8: prog.push_back(enc_sw(rnd(8), 0, 4 * rnd(64)));
				default: prog.push_back(enc_i(OPC_LOAD, F3_WORD, rnd(8), 0, 4 * rnd(64)));
			endcase
		end
		for (int r = 1; r < 8; r++)
			prog.push_back(enc_sw(r, 0, 512 + 4 * r));
	endtask

	initial begin
		rst_n          = 1'b0;
		imem_rsp_valid = 1'b0;
		imem_rsp_inst  = '0;
		dmem_req_ready = 1'b0;
		dmem_rsp_valid = 1'b0;
		dmem_rsp_rdata = '0;
		st_fire        = 1'b0;
		hung           = 1'b0;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		build_imm();
		run_test("imm_alu");
		build_reg();
		run_test("reg_alu");
		build_hazard();
		run_test("hazard");
		build_mem();
		run_test("load_store");
		for (int i = 0; i < 4; i++) begin
			build_random();
			run_test("random");
		end
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- filelist.f
verilog/core_pkg.sv
verilog/core_ifu.sv
verilog/core_idu.sv
verilog/core_exu.sv
verilog/core_lsu.sv
verilog/core_gpr.sv
verilog/core_scb.sv
verilog/core_top.sv
+incdir+testbench
testbench/tb_core.sv
